/* logic/glm_pkg.sv */
`default_nettype none

package glm_pkg;

    // *******************************************************************
    // word and line geometry
    // *******************************************************************
    localparam int data_width = 32;
    localparam int frac_bits = 16;
    localparam int words_per_line = 4;
    localparam int line_width = data_width * words_per_line;
    localparam int pos_bits = 2;
    localparam int mem_addr_width = 8;
    localparam int index_width = 16;
    localparam int grad_addr_width = 16;

    // gradient fifo sizing
    localparam int grad_fifo_depth = 8;
    localparam int grad_fifo_margin = 4;

    // fixed latencies of the arithmetic units
    localparam int sub_latency = 2;
    localparam int mult_latency = 3;
    localparam int l1_latency = 2;

    typedef enum logic
    {
        algo_sgd,
        algo_scd
    } glm_algo_t;

    typedef enum logic [1:0]
    {
        state_idle,
        state_sgd_main,
        state_scd_main
    } modify_state_t;

endpackage

`default_nettype wire

/* logic/fix_sub.sv */
`timescale 1ns/1ps
`default_nettype none

module fix_sub
    import glm_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [data_width-1:0] in_a,
    input  logic [data_width-1:0] in_b,
    output logic                  out_valid,
    output logic [data_width-1:0] result
);
    logic [data_width-1:0]  a_q;
    logic [data_width-1:0]  b_q;
    logic [sub_latency-1:0] valid_pipe;

    // operand stage, then difference stage (wraps at 32 bits)
    always_ff @(posedge clk)
    begin
        a_q <= in_a;
        b_q <= in_b;
        result <= a_q - b_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[sub_latency-2:0], in_valid};
    end

    assign out_valid = valid_pipe[sub_latency-1];

endmodule

`default_nettype wire

/* logic/fix_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module fix_mult
    import glm_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [data_width-1:0] in_a,
    input  logic [data_width-1:0] in_b,
    output logic                  out_valid,
    output logic [data_width-1:0] result
);
    logic [data_width-1:0]          a_q;
    logic [data_width-1:0]          b_q;
    logic signed [2*data_width-1:0] product;
    logic [mult_latency-1:0]        valid_pipe;

    // operand register, full signed product, then q16.16 truncation
    always_ff @(posedge clk)
    begin
        a_q <= in_a;
        b_q <= in_b;
        product <= $signed(a_q) * $signed(b_q);
        // same bits as an arithmetic shift by frac_bits
        result <= product[frac_bits +: data_width];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[mult_latency-2:0], in_valid};
    end

    assign out_valid = valid_pipe[mult_latency-1];

    // every result comes out exactly mult_latency cycles after its operands
    assert property (@(posedge clk) disable iff (reset)
        in_valid |-> ##mult_latency out_valid);
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(in_valid, mult_latency));

endmodule

`default_nettype wire

/* logic/l1_shrink.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_shrink
    import glm_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [data_width-1:0] model,
    input  logic [data_width-1:0] step,
    input  logic [data_width-1:0] lambda,
    output logic                  out_valid,
    output logic [data_width-1:0] out_step
);
    logic [data_width-1:0] step_q;
    logic [data_width-1:0] lambda_q;
    logic                  model_neg;
    logic                  model_zero;
    logic [l1_latency-1:0] valid_pipe;

    // stage one classifies the sign of the model word
    always_ff @(posedge clk)
    begin
        step_q <= step;
        lambda_q <= lambda;
        model_neg <= model[data_width-1];
        model_zero <= (model == '0);
    end

    // stage two pushes the step away from zero by lambda,
    // so that model - out_step shrinks toward zero
    always_ff @(posedge clk)
    begin
        if (model_zero)
            out_step <= step_q;
        else if (model_neg)
            out_step <= step_q - lambda_q;
        else
            out_step <= step_q + lambda_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[l1_latency-2:0], in_valid};
    end

    assign out_valid = valid_pipe[l1_latency-1];

endmodule

`default_nettype wire

/* logic/gradient_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module gradient_writer
    import glm_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  logic [grad_addr_width-1:0] grad_base,
    input  logic                       push,
    input  logic [data_width-1:0]      push_data,
    input  logic                       grad_full,
    output logic                       almost_full,
    output logic                       grad_we,
    output logic [grad_addr_width-1:0] grad_waddr,
    output logic [data_width-1:0]      grad_wdata
);
    logic [data_width-1:0]              fifo_mem [grad_fifo_depth];
    logic [$clog2(grad_fifo_depth)-1:0] wr_ptr;
    logic [$clog2(grad_fifo_depth)-1:0] rd_ptr;
    logic [$clog2(grad_fifo_depth):0]   count;
    logic                               pop;

    // head of the fifo goes straight to the region port
    assign pop = (count != '0) && !grad_full;
    assign grad_we = pop;
    assign grad_wdata = fifo_mem[rd_ptr];
    assign almost_full = (count >= grad_fifo_depth - grad_fifo_margin);

    always_ff @(posedge clk)
    begin
        if (push)
            fifo_mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // consecutive addresses from grad_base
    always_ff @(posedge clk)
    begin
        if (start)
            grad_waddr <= grad_base;
        else if (pop)
            grad_waddr <= grad_waddr + 1'b1;
    end

    // issue throttling upstream must keep the fifo from filling up
    assert property (@(posedge clk) disable iff (reset)
        push |-> (count != grad_fifo_depth));

endmodule

`default_nettype wire

/* logic/label_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module label_mem
    import glm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      re,
    input  logic [mem_addr_width-1:0] raddr,
    output logic [line_width-1:0]     rdata,
    output logic                      rvalid,
    input  logic                      we,
    input  logic [mem_addr_width-1:0] waddr,
    input  logic [line_width-1:0]     wdata,
    input  logic                      host_we,
    input  logic [mem_addr_width-1:0] host_addr,
    input  logic [line_width-1:0]     host_wdata,
    output logic [line_width-1:0]     host_rdata
);
    logic [line_width-1:0] mem [1 << mem_addr_width];

    // rdata holds its value until the next read
    always_ff @(posedge clk)
    begin
        if (re)
            rdata <= mem[raddr];
        if (we)
            mem[waddr] <= wdata;
        else if (host_we)
            mem[host_addr] <= host_wdata;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            rvalid <= 1'b0;
        else
            rvalid <= re;
    end

    // host readback, only meaningful while the stage is idle
    assign host_rdata = mem[host_addr];

    assert property (@(posedge clk) disable iff (reset) !(host_we && we));

endmodule

`default_nettype wire

/* logic/glm_modify.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_modify
    import glm_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      op_start,
    output logic                      op_done,
    input  logic [index_width-1:0]    start_index,
    input  logic [index_width-1:0]    num_iterations,
    input  logic [mem_addr_width-1:0] label_base,
    input  glm_algo_t                 algorithm,
    input  logic [data_width-1:0]     step_size,
    input  logic [data_width-1:0]     lambda,
    input  logic                      dot_empty,
    output logic                      dot_re,
    input  logic [data_width-1:0]     dot_rdata,
    input  logic                      dot_rvalid,
    output logic                      mem_re,
    output logic [mem_addr_width-1:0] mem_raddr,
    input  logic [line_width-1:0]     mem_rdata,
    input  logic                      mem_rvalid,
    output logic                      mem_we,
    output logic [mem_addr_width-1:0] mem_waddr,
    output logic [line_width-1:0]     mem_wdata,
    output logic                      sub_valid_in,
    output logic [data_width-1:0]     sub_a,
    output logic [data_width-1:0]     sub_b,
    input  logic [data_width-1:0]     sub_result,
    input  logic                      sub_valid,
    output logic                      mult_valid_in,
    output logic [data_width-1:0]     mult_a,
    output logic [data_width-1:0]     mult_b,
    input  logic [data_width-1:0]     mult_result,
    input  logic                      mult_valid,
    output logic                      l1_valid_in,
    output logic [data_width-1:0]     l1_model,
    output logic [data_width-1:0]     l1_step,
    output logic [data_width-1:0]     l1_lambda,
    input  logic [data_width-1:0]     l1_result,
    input  logic                      l1_valid,
    output logic                      writer_start,
    output logic                      push,
    output logic [data_width-1:0]     push_data,
    input  logic                      almost_full
);
    // *******************************************************************
    // captured configuration and progress
    // *******************************************************************
    modify_state_t             state;
    logic [index_width-1:0]    num_iter_q;
    logic [index_width-1:0]    start_q;
    logic [mem_addr_width-1:0] base_q;
    logic [data_width-1:0]     step_q;
    logic [index_width-1:0]    issue_count;
    logic [index_width-1:0]    done_count;
    logic [index_width-1:0]    rd_index;
    logic [index_width-1:0]    wr_index;
    logic [line_width-1:0]     line_q;
    logic                      last_commit;

    logic [index_width-1:0]    issue_index;
    logic [index_width-1:0]    raddr_index;
    logic [index_width-1:0]    in_flight;
    logic [index_width-1:0]    flight_limit;
    logic                      issue;

    // *******************************************************************
    // iteration issue
    // *******************************************************************
    assign issue_index = start_q + issue_count;
    assign in_flight = issue_count - done_count;
    // scd keeps a single iteration in flight, sgd is bounded by the fifo margin
    assign flight_limit = (state == state_sgd_main) ? index_width'(grad_fifo_margin)
                                                    : index_width'(1);
    assign issue = (state != state_idle) && !dot_empty && !almost_full
                   && (issue_count < num_iter_q) && (in_flight < flight_limit);

    assign dot_re = issue;
    // scd reads the model line one cycle after the multiply starts
    assign mem_re = (state == state_sgd_main) ? issue
                                              : (state == state_scd_main) && mult_valid_in;
    assign raddr_index = (state == state_scd_main) ? rd_index : issue_index;
    assign mem_raddr = base_q + raddr_index[pos_bits +: mem_addr_width];

    always_ff @(posedge clk)
    begin
        writer_start <= 1'b0;
        sub_valid_in <= 1'b0;
        mult_valid_in <= 1'b0;
        l1_valid_in <= 1'b0;
        mem_we <= 1'b0;
        push <= 1'b0;
        last_commit <= 1'b0;
        op_done <= last_commit;

        if (issue)
            issue_count <= issue_count + 1'b1;

        case (state)
            state_idle:
            begin
                if (op_start)
                begin
                    num_iter_q <= num_iterations;
                    start_q <= start_index;
                    base_q <= label_base;
                    step_q <= step_size;
                    l1_lambda <= lambda;
                    issue_count <= '0;
                    done_count <= '0;
                    rd_index <= start_index;
                    wr_index <= start_index;
                    writer_start <= 1'b1;
                    state <= (algorithm == algo_sgd) ? state_sgd_main : state_scd_main;
                end
            end

            // dot - label, times step, then out
            state_sgd_main:
            begin
                if (dot_rvalid && mem_rvalid)
                begin
                    sub_valid_in <= 1'b1;
                    sub_a <= dot_rdata;
                    sub_b <= mem_rdata[rd_index[pos_bits-1:0]*data_width +: data_width];
                    rd_index <= rd_index + 1'b1;
                end

                if (sub_valid)
                begin
                    mult_valid_in <= 1'b1;
                    mult_a <= step_q;
                    mult_b <= sub_result;
                end

                if (mult_valid)
                begin
                    push <= 1'b1;
                    push_data <= mult_result;
                    done_count <= done_count + 1'b1;
                    if (done_count == num_iter_q - 1'b1)
                    begin
                        last_commit <= 1'b1;
                        state <= state_idle;
                    end
                end
            end

            // step * dot, shrink, stream out, then write model - out back
            state_scd_main:
            begin
                if (dot_rvalid)
                begin
                    mult_valid_in <= 1'b1;
                    mult_a <= step_q;
                    mult_b <= dot_rdata;
                end

                if (mem_rvalid)
                    line_q <= mem_rdata;

                if (mult_valid)
                begin
                    l1_valid_in <= 1'b1;
                    l1_model <= line_q[rd_index[pos_bits-1:0]*data_width +: data_width];
                    l1_step <= mult_result;
                    rd_index <= rd_index + 1'b1;
                end

                if (l1_valid)
                begin
                    sub_valid_in <= 1'b1;
                    sub_a <= l1_model;
                    sub_b <= l1_result;
                    push <= 1'b1;
                    push_data <= l1_result;
                end

                if (sub_valid)
                begin
                    mem_we <= 1'b1;
                    mem_waddr <= base_q + wr_index[pos_bits +: mem_addr_width];
                    // merge the new model word into the fetched line
                    for (int i = 0; i < words_per_line; i++)
                    begin
                        mem_wdata[i*data_width +: data_width] <=
                            (i == wr_index[pos_bits-1:0]) ? sub_result
                                                          : line_q[i*data_width +: data_width];
                    end
                    wr_index <= wr_index + 1'b1;
                    done_count <= done_count + 1'b1;
                    if (done_count == num_iter_q - 1'b1)
                    begin
                        last_commit <= 1'b1;
                        state <= state_idle;
                    end
                end
            end

            default:
            begin
                state <= state_idle;
            end
        endcase

        if (reset)
        begin
            state <= state_idle;
            writer_start <= 1'b0;
            sub_valid_in <= 1'b0;
            mult_valid_in <= 1'b0;
            l1_valid_in <= 1'b0;
            mem_we <= 1'b0;
            push <= 1'b0;
            last_commit <= 1'b0;
            op_done <= 1'b0;
        end
    end

    // dot fifo and label memory answer in the same cycle during sgd
    assert property (@(posedge clk) disable iff (reset)
        (state == state_sgd_main) |-> (dot_rvalid == mem_rvalid));

endmodule

`default_nettype wire

/* logic/glm_update_top.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_update_top
    import glm_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       op_start,
    output logic                       op_done,
    input  logic [index_width-1:0]     start_index,
    input  logic [index_width-1:0]     num_iterations,
    input  logic [mem_addr_width-1:0]  label_base,
    input  glm_algo_t                  algorithm,
    input  logic [data_width-1:0]      step_size,
    input  logic [data_width-1:0]      lambda,
    input  logic [grad_addr_width-1:0] grad_base,
    input  logic                       dot_empty,
    output logic                       dot_re,
    input  logic [data_width-1:0]      dot_rdata,
    input  logic                       dot_rvalid,
    input  logic                       grad_full,
    output logic                       grad_we,
    output logic [grad_addr_width-1:0] grad_waddr,
    output logic [data_width-1:0]      grad_wdata,
    input  logic                       host_we,
    input  logic [mem_addr_width-1:0]  host_addr,
    input  logic [line_width-1:0]      host_wdata,
    output logic [line_width-1:0]      host_rdata
);
    logic                      mem_re;
    logic [mem_addr_width-1:0] mem_raddr;
    logic [line_width-1:0]     mem_rdata;
    logic                      mem_rvalid;
    logic                      mem_we;
    logic [mem_addr_width-1:0] mem_waddr;
    logic [line_width-1:0]     mem_wdata;

    logic                      sub_valid_in;
    logic [data_width-1:0]     sub_a;
    logic [data_width-1:0]     sub_b;
    logic [data_width-1:0]     sub_result;
    logic                      sub_valid;
    logic                      mult_valid_in;
    logic [data_width-1:0]     mult_a;
    logic [data_width-1:0]     mult_b;
    logic [data_width-1:0]     mult_result;
    logic                      mult_valid;
    logic                      l1_valid_in;
    logic [data_width-1:0]     l1_model;
    logic [data_width-1:0]     l1_step;
    logic [data_width-1:0]     l1_lambda;
    logic [data_width-1:0]     l1_result;
    logic                      l1_valid;

    logic                      writer_start;
    logic                      push;
    logic [data_width-1:0]     push_data;
    logic                      almost_full;

    glm_modify u_modify (
        .clk, .reset, .op_start, .op_done,
        .start_index, .num_iterations, .label_base, .algorithm, .step_size, .lambda,
        .dot_empty, .dot_re, .dot_rdata, .dot_rvalid,
        .mem_re, .mem_raddr, .mem_rdata, .mem_rvalid, .mem_we, .mem_waddr, .mem_wdata,
        .sub_valid_in, .sub_a, .sub_b, .sub_result, .sub_valid,
        .mult_valid_in, .mult_a, .mult_b, .mult_result, .mult_valid,
        .l1_valid_in, .l1_model, .l1_step, .l1_lambda, .l1_result, .l1_valid,
        .writer_start, .push, .push_data, .almost_full
    );

    // one subtractor and one multiplier serve both algorithms
    fix_sub u_sub (
        .clk, .reset, .in_valid(sub_valid_in), .in_a(sub_a), .in_b(sub_b),
        .out_valid(sub_valid), .result(sub_result)
    );

    fix_mult u_mult (
        .clk, .reset, .in_valid(mult_valid_in), .in_a(mult_a), .in_b(mult_b),
        .out_valid(mult_valid), .result(mult_result)
    );

    l1_shrink u_l1 (
        .clk, .reset, .in_valid(l1_valid_in), .model(l1_model), .step(l1_step),
        .lambda(l1_lambda), .out_valid(l1_valid), .out_step(l1_result)
    );

    label_mem u_mem (
        .clk, .reset,
        .re(mem_re), .raddr(mem_raddr), .rdata(mem_rdata), .rvalid(mem_rvalid),
        .we(mem_we), .waddr(mem_waddr), .wdata(mem_wdata),
        .host_we, .host_addr, .host_wdata, .host_rdata
    );

    gradient_writer u_writer (
        .clk, .reset, .start(writer_start), .grad_base, .push, .push_data,
        .grad_full, .almost_full, .grad_we, .grad_waddr, .grad_wdata
    );

endmodule

`default_nettype wire

/* verification/glm_update_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module glm_update_tb
    import glm_pkg::*;
();
    typedef struct {
        string                 name;
        glm_algo_t             algo;
        int                    start;
        int                    iters;
        logic [data_width-1:0] step;
        logic [data_width-1:0] lambda;
        int                    gap_pct;
        int                    full_pct;
    } case_t;

    logic                       clk;
    logic                       reset;
    logic                       op_start;
    logic                       op_done;
    logic [index_width-1:0]     start_index;
    logic [index_width-1:0]     num_iterations;
    logic [mem_addr_width-1:0]  label_base;
    glm_algo_t                  algorithm;
    logic [data_width-1:0]      step_size;
    logic [data_width-1:0]      lambda;
    logic [grad_addr_width-1:0] grad_base;
    logic                       dot_empty;
    logic                       dot_re;
    logic [data_width-1:0]      dot_rdata;
    logic                       dot_rvalid;
    logic                       grad_full;
    logic                       grad_we;
    logic [grad_addr_width-1:0] grad_waddr;
    logic [data_width-1:0]      grad_wdata;
    logic                       host_we;
    logic [mem_addr_width-1:0]  host_addr;
    logic [line_width-1:0]      host_wdata;
    logic [line_width-1:0]      host_rdata;

    case_t                      cases[$];
    case_t                      cur;
    logic [data_width-1:0]      dot_q[$];
    logic [data_width-1:0]      exp_grad[$];
    logic [line_width-1:0]      exp_image [1 << mem_addr_width];
    logic [mem_addr_width-1:0]  base_cur;
    logic [grad_addr_width-1:0] gbase_cur;
    logic                       start_req;
    logic                       re_seen;
    int                         grad_count;
    int                         done_pulses;
    int                         cycles;
    int                         cycle_limit;

    glm_update_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ********************************************************************
    // signed q16.16 reference arithmetic
    // ********************************************************************
    function automatic logic [data_width-1:0] q16_mul(input logic [data_width-1:0] a,
                                                      input logic [data_width-1:0] b);
        logic signed [2*data_width-1:0] full;
        full = $signed(a) * $signed(b);
        full = full >>> frac_bits;
        return full[data_width-1:0];
    endfunction

    // step shifted by lambda in the direction of the model sign
    function automatic logic [data_width-1:0] shrink_step(input logic [data_width-1:0] model,
                                                          input logic [data_width-1:0] step,
                                                          input logic [data_width-1:0] lam);
        if ($signed(model) > 0)
            return step + lam;
        else if ($signed(model) < 0)
            return step - lam;
        else
            return step;
    endfunction

    // roughly -4.0 to +4.0
    function automatic logic [data_width-1:0] small_value();
        return ($urandom % 32'h0008_0000) - 32'h0004_0000;
    endfunction

    // ********************************************************************
    // checking
    // ********************************************************************
    task automatic compare(input string what, input logic [line_width-1:0] expected,
                           input logic [line_width-1:0] actual);
        if (actual !== expected)
        begin
            $display("error: test %s, %s: expected %0h, actual %0h",
                     cur.name, what, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string msg);
        $display("test %s: %s", cur.name, msg);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic add_case(input string name, input glm_algo_t algo, input int start,
                            input int iters, input logic [data_width-1:0] step,
                            input logic [data_width-1:0] lam, input int gap_pct,
                            input int full_pct);
        case_t c;
        c.name = name;
        c.algo = algo;
        c.start = start;
        c.iters = iters;
        c.step = step;
        c.lambda = lam;
        c.gap_pct = gap_pct;
        c.full_pct = full_pct;
        cases.push_back(c);
    endtask

    // ********************************************************************
    // one clock cycle driven on the falling edge and sampled just after
    // ********************************************************************
    task automatic step_cycle();
        @(negedge clk);
        op_start = start_req;
        if (start_req)
        begin
            start_index = index_width'(cur.start);
            num_iterations = index_width'(cur.iters);
            label_base = base_cur;
            algorithm = cur.algo;
            step_size = cur.step;
            lambda = cur.lambda;
            grad_base = gbase_cur;
        end
        start_req = 1'b0;

        // dot fifo answers one cycle after the read
        if (re_seen)
        begin
            if (dot_q.size() == 0)
                fail_now("dot_re was raised while the dot FIFO was empty");
            dot_rdata = dot_q.pop_front();
            dot_rvalid = 1'b1;
        end
        else
        begin
            dot_rvalid = 1'b0;
        end
        dot_empty = (dot_q.size() == 0) || (($urandom % 100) < cur.gap_pct);
        grad_full = ($urandom % 100) < cur.full_pct;

        #1;
        re_seen = dot_re;
        if (op_done)
        begin
            done_pulses++;
            // the last sgd push comes one cycle before op_done
            if (cur.algo == algo_sgd && grad_count >= cur.iters)
                fail_now("op_done came after the last gradient word left the stage");
        end
        if (grad_we)
        begin
            if (grad_count >= exp_grad.size())
                fail_now("a gradient word was written beyond the expected count");
            compare($sformatf("grad_waddr of word %0d", grad_count),
                    gbase_cur + grad_addr_width'(grad_count), grad_waddr);
            compare($sformatf("grad_wdata of word %0d", grad_count),
                    exp_grad[grad_count], grad_wdata);
            grad_count++;
        end

        cycles++;
        if (cycles > cycle_limit)
            fail_now($sformatf("timeout, the stage did not finish within %0d cycles", cycles));
    endtask

    // ********************************************************************
    // host port access while the stage is idle
    // ********************************************************************
    task automatic load_lines(input logic [mem_addr_width-1:0] first, input int count);
        int k;
        for (k = 0; k < count; k++)
        begin
            @(negedge clk);
            host_we = 1'b1;
            host_addr = mem_addr_width'(first + k);
            host_wdata = exp_image[mem_addr_width'(first + k)];
        end
        @(negedge clk);
        host_we = 1'b0;
    endtask

    task automatic check_lines(input logic [mem_addr_width-1:0] first, input int count);
        int k;
        logic [mem_addr_width-1:0] addr;
        for (k = 0; k < count; k++)
        begin
            addr = mem_addr_width'(first + k);
            @(negedge clk);
            host_addr = addr;
            #1;
            compare($sformatf("memory line %0h", addr), exp_image[addr], host_rdata);
        end
    endtask

    task automatic run_case(input int idx);
        int k;
        int w;
        int index;
        int line_count;
        logic [mem_addr_width-1:0] first;
        logic [mem_addr_width-1:0] line;
        logic [pos_bits-1:0] pos;
        logic [data_width-1:0] dot;
        logic [data_width-1:0] word;
        logic [data_width-1:0] out;

        cur = cases[idx];
        base_cur = mem_addr_width'(8'h10 + idx * 8'h20);
        gbase_cur = grad_addr_width'(16'h0100 + idx * 16'h0400);
        first = mem_addr_width'(base_cur + cur.start / words_per_line);
        // touched lines plus one guard line after them
        line_count = (cur.start + cur.iters - 1) / words_per_line
                     - cur.start / words_per_line + 2;
        for (k = 0; k < line_count; k++)
        begin
            line = mem_addr_width'(first + k);
            for (w = 0; w < words_per_line; w++)
                exp_image[line][w*data_width +: data_width] =
                    (($urandom % 4) == 0) ? '0 : small_value();
        end
        load_lines(first, line_count);

        exp_grad.delete();
        dot_q.delete();
        for (k = 0; k < cur.iters; k++)
        begin
            index = cur.start + k;
            line = mem_addr_width'(base_cur + index / words_per_line);
            pos = pos_bits'(index % words_per_line);
            word = exp_image[line][pos*data_width +: data_width];
            dot = small_value();
            dot_q.push_back(dot);
            if (cur.algo == algo_sgd)
            begin
                exp_grad.push_back(q16_mul(cur.step, dot - word));
            end
            else
            begin
                out = shrink_step(word, q16_mul(cur.step, dot), cur.lambda);
                exp_grad.push_back(out);
                exp_image[line][pos*data_width +: data_width] = word - out;
            end
        end

        grad_count = 0;
        done_pulses = 0;
        re_seen = 1'b0;
        start_req = 1'b1;
        step_cycle();
        while (!(done_pulses != 0 && grad_count == cur.iters))
            step_cycle();
        // a few more cycles to catch stray words or a second op_done
        repeat (6) step_cycle();
        compare("op_done pulses", 1, done_pulses);
        compare("dots left in the FIFO", 0, dot_q.size());
        check_lines(first, line_count);
    endtask

    // ********************************************************************
    // main sequence
    // ********************************************************************
    initial
    begin
        reset = 1'b1;
        op_start = 1'b0;
        start_index = '0;
        num_iterations = '0;
        label_base = '0;
        algorithm = algo_sgd;
        step_size = '0;
        lambda = '0;
        grad_base = '0;
        dot_empty = 1'b1;
        dot_rdata = '0;
        dot_rvalid = 1'b0;
        grad_full = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        start_req = 1'b0;
        re_seen = 1'b0;
        grad_count = 0;
        done_pulses = 0;
        cycles = 0;
        void'($urandom(32'hd38efec2));

        //       name                  algo      start  n   step          lambda  gap full
        add_case("sgd_stream",         algo_sgd, 0,  12, 32'h0000_4000, 32'h0,      0,  0);
        add_case("sgd_unaligned_busy", algo_sgd, 6,  20, 32'h0001_8000, 32'h0,     30, 40);
        add_case("scd_aligned",        algo_scd, 0,   8, 32'h0000_8000, 32'h1000,   0,  0);
        add_case("scd_unaligned_busy", algo_scd, 3,  10, 32'h0000_6000, 32'h2000,  25, 50);
        add_case("sgd_single",         algo_sgd, 13,  1, 32'h0001_0000, 32'h0,      0,  0);
        add_case("sgd_heavy_full",     algo_sgd, 2,  24, 32'hffff_c000, 32'h0,     10, 70);

        cycle_limit = 200;
        foreach (cases[i])
            cycle_limit += cases[i].iters * 20;

        repeat (2) @(negedge clk);
        reset = 1'b0;

        // quiet outputs until the first op_start
        cur.name = "after_reset";
        repeat (4) step_cycle();
        compare("op_done pulses after reset", 0, done_pulses);

        foreach (cases[i])
            run_case(i);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/glm_pkg.sv
logic/fix_sub.sv
logic/fix_mult.sv
logic/l1_shrink.sv
logic/gradient_writer.sv
logic/label_mem.sv
logic/glm_modify.sv
logic/glm_update_top.sv
verification/glm_update_tb.sv

/* Bender.yml */
package:
  name: glm_update

sources:
  - logic/glm_pkg.sv
  - logic/fix_sub.sv
  - logic/fix_mult.sv
  - logic/l1_shrink.sv
  - logic/gradient_writer.sv
  - logic/label_mem.sv
  - logic/glm_modify.sv
  - logic/glm_update_top.sv
  - target: test
    files:
      - verification/glm_update_tb.sv
